/* lsu_pkg.sv */
// shared widths, access size encoding and the outstanding access entry
package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN  = 32;        // data and address width
  localparam int BE_W  = XLEN / 8;  // one enable per byte lane
  localparam int OFF_W = 2;         // byte offset inside a word

  //////////////////////////////////////////////////////////////////////
  // access size
  //////////////////////////////////////////////////////////////////////

  // 00 word, 01 half, 1x byte (2'b11 also decodes as byte)
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  //////////////////////////////////////////////////////////////////////
  // outstanding access control, one per granted request
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    lsu_type_e        dtype;     // size of the access
    logic [OFF_W-1:0] offset;    // addr[1:0] at issue, used to align rdata
    logic             sign_ext;  // sign extend loaded half/byte
    logic             we;        // store, response carries no load data
  } lsu_entry_t;

endpackage

/* lsu_push_if.sv */
// issue handshake from the request stage into the outstanding queue
`timescale 1ns/1ps

interface lsu_push_if;

  logic                valid;     // aligned request on the bus this cycle
  lsu_pkg::lsu_entry_t entry;     // control of that request
  logic                accepted;  // valid and granted, queue pushes entry
  logic                ready;     // queue still has a free slot

  // request side presents the access
  modport req (
    output valid,
    output entry,
    output accepted,
    input  ready
  );

  // queue side stores it and reports space
  modport queue (
    input  valid,
    input  entry,
    input  accepted,
    output ready
  );

endinterface

/* lsu_request.sv */
// address generation, alignment check, byte enables, store data rotation, bus request
`timescale 1ns/1ps

module lsu_request (
  input  logic                          data_req_ex_i,      // ex stage wants a transfer
  input  logic                          data_we_ex_i,       // store when high
  input  logic                          addr_useincr_ex_i,  // a + b, else a alone
  input  logic                          sign_ext_ex_i,
  input  lsu_pkg::lsu_type_e            data_type_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]      operand_a_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]      operand_b_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]      data_wdata_ex_i,
  input  logic                          data_gnt_i,
  output logic                          data_req_o,
  output logic                          data_we_o,
  output logic                          misaligned_o,       // pipeline traps on this
  output logic [lsu_pkg::XLEN-1:0]      data_addr_o,
  output logic [lsu_pkg::XLEN-1:0]      data_wdata_o,
  output logic [lsu_pkg::BE_W-1:0]      data_be_o,
  lsu_push_if.req                       push
);

  logic [lsu_pkg::XLEN-1:0]  addr;       // effective address
  logic [lsu_pkg::OFF_W-1:0] offset;     // byte position inside the word
  logic [lsu_pkg::BE_W-1:0]  be_base;    // enables before the shift by offset

  //////////////////////////////////////////////////////////////////////
  // address and alignment
  //////////////////////////////////////////////////////////////////////

  assign addr   = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign offset = addr[lsu_pkg::OFF_W-1:0];

  // word needs offset 0, half must not cross the word at offset 3
  always_comb begin
    misaligned_o = 1'b0;
    if (data_req_ex_i) begin
      case (data_type_ex_i)
        lsu_pkg::LSU_WORD: misaligned_o = (offset != 2'b00);
        lsu_pkg::LSU_HALF: misaligned_o = (offset == 2'b11);
        default:           misaligned_o = 1'b0;  // bytes always fit
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // byte enables and store data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (data_type_ex_i)
      lsu_pkg::LSU_WORD: be_base = 4'b1111;
      lsu_pkg::LSU_HALF: be_base = 4'b0011;
      default:           be_base = 4'b0001;  // 10 and 11 are byte
    endcase
  end

  assign data_be_o = be_base << offset;  // move enables up to the addressed lane

  // rotate left so that the low byte of the register lands on lane offset
  always_comb begin
    case (offset)
      2'b00: data_wdata_o = data_wdata_ex_i;
      2'b01: data_wdata_o = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'b10: data_wdata_o = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: data_wdata_o = {data_wdata_ex_i[7:0], data_wdata_ex_i[31:8]};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // bus request and queue entry
  //////////////////////////////////////////////////////////////////////

  // only aligned accesses with a free queue slot go out
  assign push.valid    = data_req_ex_i & ~misaligned_o & push.ready;
  assign push.accepted = push.valid & data_gnt_i;  // grant closes the address phase

  assign push.entry.dtype    = data_type_ex_i;
  assign push.entry.offset   = offset;
  assign push.entry.sign_ext = sign_ext_ex_i;
  assign push.entry.we       = data_we_ex_i;

  assign data_req_o  = push.valid;     // held with stable payload until grant
  assign data_addr_o = addr;
  assign data_we_o   = data_we_ex_i;

endmodule

/* lsu_wb_queue.sv */
// in-order queue of outstanding access control with counter, ready and busy logic
`timescale 1ns/1ps

module lsu_wb_queue #(
  parameter int DEPTH = 2  // max accesses in flight
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                data_req_ex_i,   // aligned request from ex
  input  logic                data_rvalid_i,   // response pops the head
  output lsu_pkg::lsu_entry_t head_o,          // oldest outstanding access
  output logic                lsu_ready_ex_o,
  output logic                lsu_ready_wb_o,
  output logic                busy_o,
  lsu_push_if.queue           push
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  lsu_pkg::lsu_entry_t mem_q [DEPTH];  // entry storage
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    cnt_q;          // granted but not yet answered
  logic                empty;
  logic                full;

  // circular increment, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push.accepted) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (data_rvalid_i) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push.accepted, data_rvalid_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // none, or push and pop together
      endcase
    end
  end

  // payload only, written on grant
  always_ff @(posedge clk) begin
    if (push.accepted) mem_q[wr_ptr_q] <= push.entry;
  end

  assign head_o = mem_q[rd_ptr_q];  // valid while cnt_q != 0

  //////////////////////////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////////////////////////

  assign empty      = (cnt_q == '0);
  assign full       = (cnt_q == CNT_W'(DEPTH));
  assign push.ready = ~full;

  assign busy_o         = ~empty | push.valid;         // in flight or about to be
  assign lsu_ready_wb_o = empty ? 1'b1 : data_rvalid_i;

  // ex may only advance once wb can move in lock step
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;
    end else if (empty) begin
      lsu_ready_ex_o = push.accepted;                  // grant alone
    end else if (full) begin
      lsu_ready_ex_o = data_rvalid_i;                  // already issued, wait for wb
    end else begin
      lsu_ready_ex_o = data_rvalid_i & push.accepted;
    end
  end

endmodule

/* load_byte_lane.sv */
// one byte of the load result, picked from returned data or filled with extension
`timescale 1ns/1ps

module load_byte_lane #(
  parameter int LANE = 0  // result byte this instance drives, 0 to 3
) (
  input  logic [lsu_pkg::XLEN-1:0] rdata_i,  // raw bus read data
  input  lsu_pkg::lsu_entry_t      head_i,   // control of the answered access
  output logic [7:0]               byte_o
);

  logic [lsu_pkg::OFF_W-1:0] src_idx;   // source byte in rdata
  logic [lsu_pkg::OFF_W-1:0] msb_idx;   // byte holding the loaded sign bit
  logic                      use_src;   // lane lies inside the loaded value
  logic [7:0]                src_byte;
  logic                      top_bit;
  logic [7:0]                ext_byte;

  always_comb begin
    case (head_i.dtype)
      lsu_pkg::LSU_WORD: begin
        use_src = 1'b1;
        src_idx = lsu_pkg::OFF_W'(LANE);  // words are aligned, straight through
        msb_idx = 2'd3;
      end
      lsu_pkg::LSU_HALF: begin
        use_src = (LANE < 2);
        src_idx = head_i.offset + lsu_pkg::OFF_W'(LANE);
        msb_idx = head_i.offset + 2'd1;   // upper byte of the half
      end
      default: begin                      // byte
        use_src = (LANE == 0);
        src_idx = head_i.offset;
        msb_idx = head_i.offset;
      end
    endcase
  end

  assign src_byte = rdata_i[{src_idx, 3'b000} +: 8];
  assign top_bit  = rdata_i[{msb_idx, 3'b111}];
  assign ext_byte = {8{head_i.sign_ext & top_bit}};  // zero unless signed and negative

  assign byte_o = use_src ? src_byte : ext_byte;

endmodule

/* lsu_core.sv */
// load/store unit top level: request stage, outstanding queue and load byte lanes
`timescale 1ns/1ps

module lsu_core #(
  parameter int DEPTH = 2  // outstanding bus transactions
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // execute stage
  input  logic                          data_req_ex_i,
  input  logic                          data_we_ex_i,
  input  lsu_pkg::lsu_type_e            data_type_ex_i,
  input  logic                          addr_useincr_ex_i,
  input  logic                          sign_ext_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]      operand_a_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]      operand_b_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]      data_wdata_ex_i,
  output logic [lsu_pkg::XLEN-1:0]      data_rdata_ex_o,   // valid with data_rvalid_i
  output logic                          misaligned_o,
  output logic                          lsu_ready_ex_o,
  output logic                          lsu_ready_wb_o,
  output logic                          busy_o,

  // data bus
  output logic                          data_req_o,
  input  logic                          data_gnt_i,
  input  logic                          data_rvalid_i,
  output logic [lsu_pkg::XLEN-1:0]      data_addr_o,
  output logic                          data_we_o,
  output logic [lsu_pkg::BE_W-1:0]      data_be_o,
  output logic [lsu_pkg::XLEN-1:0]      data_wdata_o,
  input  logic [lsu_pkg::XLEN-1:0]      data_rdata_i
);

  lsu_pkg::lsu_entry_t head;  // control of the access being answered

  lsu_push_if push ();

  ////////////////////////////////////////////////////////////////////////
  // request stage
  ////////////////////////////////////////////////////////////////////////

  lsu_request u_request (
    .data_req_ex_i     (data_req_ex_i),
    .data_we_ex_i      (data_we_ex_i),
    .addr_useincr_ex_i (addr_useincr_ex_i),
    .sign_ext_ex_i     (sign_ext_ex_i),
    .data_type_ex_i    (data_type_ex_i),
    .operand_a_ex_i    (operand_a_ex_i),
    .operand_b_ex_i    (operand_b_ex_i),
    .data_wdata_ex_i   (data_wdata_ex_i),
    .data_gnt_i        (data_gnt_i),
    .data_req_o        (data_req_o),
    .data_we_o         (data_we_o),
    .misaligned_o      (misaligned_o),
    .data_addr_o       (data_addr_o),
    .data_wdata_o      (data_wdata_o),
    .data_be_o         (data_be_o),
    .push              (push.req)
  );

  ////////////////////////////////////////////////////////////////////////
  // outstanding queue, a misaligned request counts as no request here
  ////////////////////////////////////////////////////////////////////////

  lsu_wb_queue #(
    .DEPTH (DEPTH)
  ) u_wb_queue (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i & ~misaligned_o),  // trap path sees ready at once
    .data_rvalid_i  (data_rvalid_i),
    .head_o         (head),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .push           (push.queue)
  );

  ////////////////////////////////////////////////////////////////////////
  // load alignment and extension, one lane per result byte
  ////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < lsu_pkg::BE_W; i++) begin : g_lane
    load_byte_lane #(
      .LANE (i)
    ) u_lane (
      .rdata_i (data_rdata_i),
      .head_i  (head),
      .byte_o  (data_rdata_ex_o[8*i +: 8])
    );
  end

endmodule

/* lsu_asserts.sv */
// bus handshake and occupancy assertions, bound into the lsu top level
`timescale 1ns/1ps

module lsu_asserts (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          data_req_i,
  input logic                          data_gnt_i,
  input logic                          data_rvalid_i,
  input logic                          data_we_i,
  input logic                          busy_i,
  input logic [lsu_pkg::XLEN-1:0]      data_addr_i,
  input logic [lsu_pkg::BE_W-1:0]      data_be_i
);

  // an ungranted request stays up with the same payload
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i)
      && $stable(data_be_i) && $stable(data_we_i))
    else $error("bus request dropped or changed before grant");

  rvalid_busy: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> busy_i)  // a response needs something in flight
    else $error("response while the unit is idle");

  busy_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !busy_i)
    else $error("busy right after reset");

endmodule

bind lsu_core lsu_asserts u_asserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .data_req_i    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_we_i     (data_we_o),
  .busy_i        (busy_o),
  .data_addr_i   (data_addr_o),
  .data_be_i     (data_be_o)
);

/* tb_lsu_core.sv */
// lsu_core testbench with clock, reset, random loads and stores, bus memory model and checks
`timescale 1ns/1ps

module tb_lsu_core;

  localparam int DEPTH   = 2;
  localparam int XLEN    = lsu_pkg::XLEN;
  localparam int N_OPS   = 400;
  localparam int MAX_CYC = 20 * N_OPS;  // ops average about 3 cycles so this leaves a wide margin

  logic                     clk;
  logic                     rst_n;
  logic                     data_req_ex_i;
  logic                     data_we_ex_i;
  lsu_pkg::lsu_type_e       data_type_ex_i;
  logic                     addr_useincr_ex_i;
  logic                     sign_ext_ex_i;
  logic [XLEN-1:0]          operand_a_ex_i;
  logic [XLEN-1:0]          operand_b_ex_i;
  logic [XLEN-1:0]          data_wdata_ex_i;
  logic [XLEN-1:0]          data_rdata_ex_o;
  logic                     misaligned_o;
  logic                     lsu_ready_ex_o;
  logic                     lsu_ready_wb_o;
  logic                     busy_o;
  logic                     data_req_o;
  logic                     data_gnt_i;
  logic                     data_rvalid_i;
  logic [XLEN-1:0]          data_addr_o;
  logic                     data_we_o;
  logic [lsu_pkg::BE_W-1:0] data_be_o;
  logic [XLEN-1:0]          data_wdata_o;
  logic [XLEN-1:0]          data_rdata_i;

  logic [XLEN-1:0] bus_mem [256];       // words the bus model returns
  logic [XLEN-1:0] ref_mem [256];       // reference view merged from ex-stage data
  int unsigned     rsp_due_q [$];       // first cycle each response may go out
  logic [XLEN-1:0] rsp_data_q [$];
  logic            exp_load_q [$];      // one per grant in order
  logic [XLEN-1:0] exp_data_q [$];
  int              outstanding = 0;     // granted and not yet answered
  int unsigned     cyc = 0;
  int unsigned     timeout_cnt = 0;
  logic            op_taken = 1'b0;     // ex request granted or trapped this cycle
  int              ops_sent = 0;
  logic [XLEN-1:0] op_addr = '0;        // address the current op was built for

  lsu_core #(
    .DEPTH (DEPTH)
  ) UUT (.*);

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  function automatic int access_size(input logic [1:0] typ);
    case (typ)
      2'b00:   return 4;
      2'b01:   return 2;
      default: return 1;
    endcase
  endfunction

  // enable every lane covered by the access
  function automatic logic [3:0] byte_enables(input logic [1:0] typ, input logic [1:0] off);
    logic [3:0] be;
    be = '0;
    for (int i = 0; i < 4; i++) begin
      if (i >= int'(off) && i < int'(off) + access_size(typ)) be[i] = 1'b1;
    end
    return be;
  endfunction

  function automatic logic [XLEN-1:0] rotate_bytes(input logic [XLEN-1:0] w,
                                                   input logic [1:0] off);
    logic [XLEN-1:0] r;
    for (int i = 0; i < 4; i++) r[8*((i + int'(off)) % 4) +: 8] = w[8*i +: 8];
    return r;
  endfunction

  // pick bytes from the offset and fill above with zero or sign
  function automatic logic [XLEN-1:0] load_result(input logic [XLEN-1:0] w,
      input logic [1:0] typ, input logic [1:0] off, input logic sgn);
    logic [XLEN-1:0] v;
    int              n;
    n = access_size(typ);
    v = '0;
    for (int i = 0; i < n; i++) v[8*i +: 8] = w[8*(int'(off) + i) +: 8];
    if (sgn && v[8*n-1]) begin
      for (int i = n; i < 4; i++) v[8*i +: 8] = 8'hff;
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic expect_eq(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // one random access that is mostly aligned so the queue gets exercised
  task automatic start_op();
    logic [1:0]      typ;
    logic [XLEN-1:0] addr;
    typ  = 2'($urandom % 3);
    addr = $urandom;
    if (($urandom % 4) != 0) begin
      if (typ == 2'b00) addr[1:0] = 2'b00;
      if (typ == 2'b01) addr[0] = 1'b0;
    end
    op_addr           = addr;
    data_type_ex_i    = lsu_pkg::lsu_type_e'(typ);
    data_we_ex_i      = 1'($urandom % 2);
    sign_ext_ex_i     = 1'($urandom % 2);
    addr_useincr_ex_i = 1'($urandom % 2);
    operand_b_ex_i    = addr_useincr_ex_i ? ($urandom % 1024) : $urandom;
    operand_a_ex_i    = addr_useincr_ex_i ? addr - operand_b_ex_i : addr;
    data_wdata_ex_i   = $urandom;
    data_req_ex_i     = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // clock, timeout, bus side
  //////////////////////////////////////////////////////////////////////

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) begin
    timeout_cnt <= timeout_cnt + 1;
    if (timeout_cnt >= MAX_CYC) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      abort_run();
    end
  end

  // random grant and in-order responses once their delay has run out
  initial begin : bus_model
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    forever begin
      @(negedge clk);
      data_gnt_i = rst_n && (($urandom % 4) != 0);
      if (rsp_due_q.size() != 0 && cyc >= rsp_due_q[0]) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = rsp_data_q[0];
      end else begin
        data_rvalid_i = 1'b0;
        data_rdata_i  = $urandom;  // junk outside a response
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // monitor sampling at the rising edge while inputs are settled
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    logic [1:0]      typ;
    logic [XLEN-1:0] addr;
    logic [1:0]      off;
    logic [7:0]      idx;
    logic            exp_mis;
    logic            exp_req;
    logic            exp_rdy;
    if (rst_n) begin
      typ     = data_type_ex_i;
      addr    = op_addr;                                     // operands were derived from it
      off     = addr[1:0];
      idx     = addr[9:2];                                   // 256 word window
      exp_mis = data_req_ex_i && (int'(off) + access_size(typ) > 4);  // crosses the word
      exp_req = data_req_ex_i && !exp_mis && (outstanding < DEPTH);
      if (data_req_o && data_gnt_i) begin
        assert (outstanding < DEPTH) else begin
          $display("bus granted a request with %0d accesses already in flight", outstanding);
          abort_run();
        end
      end
      expect_eq("misaligned_o", misaligned_o, exp_mis);
      expect_eq("data_req_o", data_req_o, exp_req);
      if (exp_req) begin
        expect_eq("data_addr_o", data_addr_o, addr);
        expect_eq("data_be_o", data_be_o, byte_enables(typ, off));
        expect_eq("data_wdata_o", data_wdata_o, rotate_bytes(data_wdata_ex_i, off));
        expect_eq("data_we_o", data_we_o, data_we_ex_i);
      end
      if (!data_req_ex_i || exp_mis) exp_rdy = 1'b1;     // idle or trap
      else if (outstanding == 0) exp_rdy = data_gnt_i;
      else if (outstanding == DEPTH) exp_rdy = data_rvalid_i;
      else exp_rdy = data_rvalid_i && data_gnt_i;
      expect_eq("lsu_ready_ex_o", lsu_ready_ex_o, exp_rdy);
      expect_eq("busy_o", busy_o, (outstanding != 0) || exp_req);
      expect_eq("lsu_ready_wb_o", lsu_ready_wb_o, (outstanding == 0) || data_rvalid_i);
      if (data_rvalid_i) begin
        if (exp_load_q[0]) expect_eq("data_rdata_ex_o", data_rdata_ex_o, exp_data_q[0]);
        exp_load_q.delete(0);
        exp_data_q.delete(0);
        rsp_due_q.delete(0);
        rsp_data_q.delete(0);
        outstanding--;
      end
      if (exp_req && data_gnt_i) begin
        if (data_we_ex_i) begin
          for (int i = 0; i < access_size(typ); i++)
            ref_mem[idx][8*(int'(off) + i) +: 8] = data_wdata_ex_i[8*i +: 8];
          for (int i = 0; i < 4; i++)
            if (data_be_o[i]) bus_mem[idx][8*i +: 8] = data_wdata_o[8*i +: 8];
          exp_load_q.push_back(1'b0);
          exp_data_q.push_back('0);
          rsp_data_q.push_back($urandom);
        end else begin
          exp_load_q.push_back(1'b1);
          exp_data_q.push_back(load_result(ref_mem[idx], typ, off, sign_ext_ex_i));
          rsp_data_q.push_back(bus_mem[idx]);              // read on grant
        end
        rsp_due_q.push_back(cyc + 1 + ($urandom % 3));     // 1 to 3 cycles later
        outstanding++;
      end
      op_taken = data_req_ex_i && (exp_mis || (exp_req && data_gnt_i));
      cyc++;
    end else begin
      op_taken = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ex-stage driver on the falling edge
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    void'($urandom(32'hc0ec_8602));
    for (int i = 0; i < 256; i++) begin
      bus_mem[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i) + 8'h33, 8'(i)};
      ref_mem[i] = bus_mem[i];
    end
    rst_n             = 1'b0;
    data_req_ex_i     = 1'b0;
    data_we_ex_i      = 1'b0;
    data_type_ex_i    = lsu_pkg::LSU_WORD;
    addr_useincr_ex_i = 1'b0;
    sign_ext_ex_i     = 1'b0;
    operand_a_ex_i    = '0;
    operand_b_ex_i    = '0;
    data_wdata_ex_i   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    expect_eq("data_req_o", data_req_o, 1'b0);  // reset state
    expect_eq("busy_o", busy_o, 1'b0);
    expect_eq("lsu_ready_wb_o", lsu_ready_wb_o, 1'b1);
    while (ops_sent < N_OPS || data_req_ex_i) begin
      @(negedge clk);
      if (!data_req_ex_i || op_taken) begin  // hold until granted or trapped
        if (ops_sent < N_OPS && ($urandom % 5) != 0) begin
          start_op();
          ops_sent++;
        end else begin
          data_req_ex_i = 1'b0;                // idle gap
        end
      end
    end
    while (outstanding != 0) @(negedge clk);
    for (int i = 0; i < 256; i++) expect_eq($sformatf("mem[%0d]", i), bus_mem[i], ref_mem[i]);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* lsu_core.f */
lsu_pkg.sv
lsu_push_if.sv
lsu_request.sv
lsu_wb_queue.sv
load_byte_lane.sv
lsu_core.sv
lsu_asserts.sv
tb_lsu_core.sv

/* run_sim.sh */
#!/bin/sh
# build the lsu_core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module tb_lsu_core \
  -f lsu_core.f \
  --Mdir obj_dir -o sim_lsu_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_lsu_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

exit 0
